// ==== include/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath and address width
`define RV_XLEN 32

// Register index width
`define RV_REG_AW 5

// Data memory depth in words
`define RV_DMEM_WORDS 256

// Fetch address step and start address
`define RV_PC_STEP 4
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rvCore testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbRvCore -f sources.f \
    -Mdir obj_dir -o simv > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/simv +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
runStatus=$?
cat "$SIM_LOG"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
    exit 1
fi

exit 0

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module decodeStage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_XLEN-1:0]   instrD,
    output logic [`RV_REG_AW-1:0] rs1Addr,
    output logic [`RV_REG_AW-1:0] rs2Addr,
    input  logic [`RV_XLEN-1:0]   rs1Val,
    input  logic [`RV_XLEN-1:0]   rs2Val,
    decExIf.source                out
);

    rvPkg::opcodeE       opcode;
    rvPkg::aluOpE        aluOpD;
    rvPkg::ctrlT         ctrlD;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] immD;

    // Instruction fields
    assign opcode  = rvPkg::opcodeE'(instrD[6:0]);
    assign funct3  = instrD[14:12];
    assign funct7  = instrD[31:25];
    assign rs1Addr = instrD[19:15];
    assign rs2Addr = instrD[24:20];

    // ALU decoder, shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000: begin
                // Only the register form has sub
                if (opcode == rvPkg::OpReg && funct7[5]) begin
                    aluOpD = rvPkg::AluSub;
                end else begin
                    aluOpD = rvPkg::AluAdd;
                end
            end
            3'b010:  aluOpD = rvPkg::AluSlt;
            3'b110:  aluOpD = rvPkg::AluOr;
            3'b111:  aluOpD = rvPkg::AluAnd;
            default: aluOpD = rvPkg::AluAdd;
        endcase
    end

    // Main decoder; loads and stores use the add default
    always_comb begin
        ctrlD = '0;
        case (opcode)
            rvPkg::OpLoad: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluSrc   = 1'b1;
                ctrlD.memToReg = 1'b1;
            end
            rvPkg::OpStore: begin
                ctrlD.aluSrc   = 1'b1;
                ctrlD.memWrite = 1'b1;
            end
            rvPkg::OpImm: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluSrc   = 1'b1;
                ctrlD.aluOp    = aluOpD;
            end
            rvPkg::OpReg: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluOp    = aluOpD;
            end
            // Unknown opcode travels as a bubble
            default: ctrlD = '0;
        endcase
    end

    // S-type offset is split around the rd field
    always_comb begin
        if (opcode == rvPkg::OpStore) begin
            immD = {{(`RV_XLEN-12){instrD[31]}}, instrD[31:25], instrD[11:7]};
        end else begin
            immD = {{(`RV_XLEN-12){instrD[31]}}, instrD[31:20]};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out.ctrl <= '0;
        end else begin
            out.ctrl <= ctrlD;
        end
    end

    // Operands and destination
    always_ff @(posedge clk) begin
        out.rs1Val <= rs1Val;
        out.rs2Val <= rs2Val;
        out.imm    <= immD;
        out.rd     <= instrD[11:7];
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module executeStage (
    input  logic   clk,
    input  logic   rst,
    decExIf.sink   in,
    exMemIf.source out
);

    logic [`RV_XLEN-1:0] srcB;
    logic [`RV_XLEN-1:0] aluResult;
    logic                lessThan;

    // Second operand, immediate for addi, lw and sw
    assign srcB = in.ctrl.aluSrc ? in.imm : in.rs2Val;

    assign lessThan = $signed(in.rs1Val) < $signed(srcB);

    // ALU
    always_comb begin
        case (in.ctrl.aluOp)
            rvPkg::AluSub: aluResult = in.rs1Val - srcB;
            rvPkg::AluAnd: aluResult = in.rs1Val & srcB;
            rvPkg::AluOr:  aluResult = in.rs1Val | srcB;
            rvPkg::AluSlt: aluResult = {{(`RV_XLEN-1){1'b0}}, lessThan};
            default:       aluResult = in.rs1Val + srcB;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out.ctrl <= '0;
        end else begin
            out.ctrl <= in.ctrl;
        end
    end

    // Store data is rs2 as read in decode
    always_ff @(posedge clk) begin
        out.aluResult <= aluResult;
        out.storeData <= in.rs2Val;
        out.rd        <= in.rd;
    end

endmodule

// ==== source/fetchStage.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module fetchStage (
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_XLEN-1:0] imemAddr,
    input  logic [`RV_XLEN-1:0] imemData,
    output logic [`RV_XLEN-1:0] instrD
);

    logic [`RV_XLEN-1:0] pc;

    // Straight-line fetch, nothing redirects the PC
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc + `RV_PC_STEP;
        end
    end

    assign imemAddr = pc;

    // Decode sees a NOP until the first fetched word lands
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            instrD <= `RV_NOP;
        end else begin
            instrD <= imemData;
        end
    end

endmodule

// ==== source/memoryStage.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module memoryStage (
    input  logic   clk,
    input  logic   rst,
    exMemIf.sink   in,
    memWbIf.source out
);

    localparam int AddrW = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [AddrW-1:0]    wordIdx;
    logic [`RV_XLEN-1:0] readData;

    // Byte address to word index, wraps at the depth
    assign wordIdx  = in.aluResult[AddrW+1:2];
    assign readData = dmem[wordIdx];

    always_ff @(posedge clk) begin
        if (in.ctrl.memWrite) begin
            dmem[wordIdx] <= in.storeData;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out.ctrl <= '0;
        end else begin
            out.ctrl <= in.ctrl;
        end
    end

    // Load data and pass-through fields
    always_ff @(posedge clk) begin
        out.loadData  <= readData;
        out.aluResult <= in.aluResult;
        out.rd        <= in.rd;
    end

endmodule

// ==== source/pipeIfs.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

// Decode to execute
interface decExIf;
    rvPkg::ctrlT           ctrl;
    logic [`RV_XLEN-1:0]   rs1Val;
    logic [`RV_XLEN-1:0]   rs2Val;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_REG_AW-1:0] rd;

    modport source (
        output ctrl, rs1Val, rs2Val, imm, rd
    );

    modport sink (
        input ctrl, rs1Val, rs2Val, imm, rd
    );
endinterface

// Execute to memory
interface exMemIf;
    rvPkg::ctrlT           ctrl;
    logic [`RV_XLEN-1:0]   aluResult;
    logic [`RV_XLEN-1:0]   storeData;
    logic [`RV_REG_AW-1:0] rd;

    modport source (
        output ctrl, aluResult, storeData, rd
    );

    modport sink (
        input ctrl, aluResult, storeData, rd
    );
endinterface

// Memory to write-back
interface memWbIf;
    rvPkg::ctrlT           ctrl;
    logic [`RV_XLEN-1:0]   aluResult;
    logic [`RV_XLEN-1:0]   loadData;
    logic [`RV_REG_AW-1:0] rd;

    modport source (
        output ctrl, aluResult, loadData, rd
    );

    modport sink (
        input ctrl, aluResult, loadData, rd
    );
endinterface

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module regFile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] rs1Addr,
    input  logic [`RV_REG_AW-1:0] rs2Addr,
    output logic [`RV_XLEN-1:0]   rs1Val,
    output logic [`RV_XLEN-1:0]   rs2Val,
    memWbIf.sink                  in,
    output logic                  wbValid,
    output logic [`RV_REG_AW-1:0] wbReg,
    output logic [`RV_XLEN-1:0]   wbData
);

    localparam int Depth = 1 << `RV_REG_AW;

    logic [`RV_XLEN-1:0] regs [Depth];
    logic [`RV_XLEN-1:0] result;

    // Write-back result select
    assign result = in.ctrl.memToReg ? in.loadData : in.aluResult;

    // Writes to x0 are dropped and do not retire
    assign wbValid = in.ctrl.regWrite && (in.rd != '0);
    assign wbReg   = in.rd;
    assign wbData  = result;

    always_ff @(posedge clk) begin
        if (wbValid) begin
            regs[in.rd] <= result;
        end
    end

    // Reads see the value from before this cycle's write
    // Entry 0 is never written, so x0 is forced to zero here
    assign rs1Val = (!rst || rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Val = (!rst || rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== source/rvCore.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvCore (
    input  logic                  clk,
    input  logic                  rst,
    output logic [`RV_XLEN-1:0]   imemAddr,
    input  logic [`RV_XLEN-1:0]   imemData,
    output logic                  wbValid,
    output logic [`RV_REG_AW-1:0] wbReg,
    output logic [`RV_XLEN-1:0]   wbData
);

    logic [`RV_XLEN-1:0]   instrD;
    logic [`RV_REG_AW-1:0] rs1Addr;
    logic [`RV_REG_AW-1:0] rs2Addr;
    logic [`RV_XLEN-1:0]   rs1Val;
    logic [`RV_XLEN-1:0]   rs2Val;

    // Stage-to-stage bundles
    decExIf decEx ();
    exMemIf exMem ();
    memWbIf memWb ();

    fetchStage i_fetchStage (
        .clk      (clk),
        .rst      (rst),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .instrD   (instrD)
    );

    decodeStage i_decodeStage (
        .clk     (clk),
        .rst     (rst),
        .instrD  (instrD),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val),
        .out     (decEx.source)
    );

    executeStage i_executeStage (
        .clk (clk),
        .rst (rst),
        .in  (decEx.sink),
        .out (exMem.source)
    );

    memoryStage i_memoryStage (
        .clk (clk),
        .rst (rst),
        .in  (exMem.sink),
        .out (memWb.source)
    );

    // Write-back lives with the register file
    regFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val),
        .in      (memWb.sink),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData)
    );

endmodule

// ==== source/rvPkg.sv ====
package rvPkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OpLoad  = 7'b0000011,
        OpStore = 7'b0100011,
        OpImm   = 7'b0010011,
        OpReg   = 7'b0110011
    } opcodeE;

    // ALU operations
    typedef enum logic [2:0] {
        AluAdd = 3'b000,
        AluSub = 3'b001,
        AluAnd = 3'b010,
        AluOr  = 3'b011,
        AluSlt = 3'b101
    } aluOpE;

    // Control bundle carried down the pipe
    // All zero means a bubble
    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;
        logic  memWrite;
        logic  memToReg;
        aluOpE aluOp;
    } ctrlT;

endpackage

// ==== sources.f ====
+incdir+include
source/rvPkg.sv
source/pipeIfs.sv
source/fetchStage.sv
source/decodeStage.sv
source/regFile.sv
source/executeStage.sv
source/memoryStage.sv
source/rvCore.sv
testbench/rvCore_props.sv
testbench/tbRvCore.sv

// ==== testbench/rvCore_props.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvCore_props (
    input logic                  clk,
    input logic                  rst,
    input logic [`RV_XLEN-1:0]   imemAddr,
    input logic                  wbValid,
    input logic [`RV_REG_AW-1:0] wbReg
);

    // First edge out of reset
    aResetState: assert property (@(posedge clk)
        $rose(rst) |-> (imemAddr == `RV_RESET_PC) && !wbValid)
        else $error("Fetch address or retirement wrong when leaving reset");

    aPcStep: assert property (@(posedge clk) disable iff (!rst)
        $past(rst) |-> imemAddr == $past(imemAddr) + `RV_PC_STEP)
        else $error("Fetch address did not advance by one step");

    aNoX0Retire: assert property (@(posedge clk) disable iff (!rst)
        wbValid |-> wbReg != '0)
        else $error("Retirement reported for x0");

endmodule

bind rvCore rvCore_props i_rvCoreProps (
    .clk      (clk),
    .rst      (rst),
    .imemAddr (imemAddr),
    .wbValid  (wbValid),
    .wbReg    (wbReg)
);

// ==== testbench/tbRvCore.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module tbRvCore;

    localparam int ProgMax = 2048;
    localparam int NumRandom = 200;

    logic                  clk;
    logic                  rst;
    logic [`RV_XLEN-1:0]   imemData;
    logic [`RV_XLEN-1:0]   imemAddr;
    logic                  wbValid;
    logic [`RV_REG_AW-1:0] wbReg;
    logic [`RV_XLEN-1:0]   wbData;

    // Program image and expected retirement per instruction slot
    logic [`RV_XLEN-1:0]   rom [ProgMax];
    logic                  expValid [ProgMax];
    logic [`RV_REG_AW-1:0] expReg [ProgMax];
    logic [`RV_XLEN-1:0]   expData [ProgMax];

    // Reference model state
    logic [`RV_XLEN-1:0] modelRegs [32];
    logic [`RV_XLEN-1:0] modelMem [`RV_DMEM_WORDS];
    int                  writtenIdx [$];

    int     progLen;
    int     valueErrs;
    int     presenceErrs;
    int     protoErrs;
    integer seed;

    int                    cycleCnt;
    int                    retIdx;
    logic                  expV;
    logic [`RV_REG_AW-1:0] expRegNow;
    logic [`RV_XLEN-1:0]   expDataNow;
    logic [`RV_XLEN-1:0]   expAddr;

    rvCore i_rvCore (
        .clk      (clk),
        .rst      (rst),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] encI(logic [6:0] opc, logic [4:0] rd, logic [2:0] f3,
                                         logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'(rvPkg::OpReg)};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'(rvPkg::OpStore)};
    endfunction

    // Each instruction is followed by three NOP slots to cover the missing forwarding
    task automatic appendInstr(logic [31:0] word, logic retire, logic [4:0] rd,
                               logic [31:0] data);
        rom[progLen] = word;
        expValid[progLen] = retire;
        expReg[progLen] = rd;
        expData[progLen] = data;
        progLen++;
        repeat (3) begin
            rom[progLen] = `RV_NOP;
            expValid[progLen] = 1'b0;
            progLen++;
        end
    endtask

    task automatic addRandomInstr();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] word;
        int          widx;
        kind = $unsigned($random(seed)) % 9;
        rd = 5'($random(seed));
        rs1 = 5'($random(seed));
        rs2 = 5'($random(seed));
        imm = 12'($random(seed));
        a = modelRegs[rs1];
        b = modelRegs[rs2];
        r = '0;
        // Nothing stored yet, so a load becomes a store
        if (kind == 6 && writtenIdx.size() == 0) begin
            kind = 7;
        end
        case (kind)
            0: begin
                r = a + {{20{imm[11]}}, imm};
                word = encI(rvPkg::OpImm, rd, 3'b000, rs1, imm);
            end
            1: begin
                r = a + b;
                word = encR(7'h00, rs2, rs1, 3'b000, rd);
            end
            2: begin
                r = a - b;
                word = encR(7'h20, rs2, rs1, 3'b000, rd);
            end
            3: begin
                r = a & b;
                word = encR(7'h00, rs2, rs1, 3'b111, rd);
            end
            4: begin
                r = a | b;
                word = encR(7'h00, rs2, rs1, 3'b110, rd);
            end
            5: begin
                r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                word = encR(7'h00, rs2, rs1, 3'b010, rd);
            end
            6: begin
                widx = writtenIdx[$unsigned($random(seed)) % writtenIdx.size()];
                r = modelMem[widx];
                word = encI(rvPkg::OpLoad, rd, 3'b010, 5'd0, 12'(widx * 4));
            end
            7: begin
                widx = $unsigned($random(seed)) % `RV_DMEM_WORDS;
                modelMem[widx] = b;
                writtenIdx.push_back(widx);
                word = encS(12'(widx * 4), rs2, 5'd0);
            end
            default: begin
                // Opcode outside the decoded set
                word = $random(seed);
                word[6:0] = {2'($random(seed)), 5'h0B};
            end
        endcase
        if (kind <= 6 && rd != 0) begin
            modelRegs[rd] = r;
            appendInstr(word, 1'b1, rd, r);
        end else begin
            appendInstr(word, 1'b0, rd, r);
        end
    endtask

    // Cycles since reset release, equal to the slot being fetched
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cycleCnt <= 0;
        end else begin
            cycleCnt <= cycleCnt + 1;
        end
    end

    // Expected fetch address and the retirement for the slot now in write-back
    always_comb begin
        retIdx = cycleCnt - 4;
        expAddr = `RV_RESET_PC + cycleCnt * `RV_PC_STEP;
        if (retIdx >= 0 && retIdx < ProgMax) begin
            expV = expValid[retIdx];
            expRegNow = expReg[retIdx];
            expDataNow = expData[retIdx];
        end else begin
            expV = 1'b0;
            expRegNow = '0;
            expDataNow = '0;
        end
    end

    // Instruction supply
    always @(posedge clk) begin
        #1;
        imemData = ((imemAddr >> 2) < ProgMax) ? rom[imemAddr >> 2] : `RV_NOP;
    end

    aPresence: assert property (@(posedge clk) disable iff (!rst) wbValid == expV)
        else begin
            presenceErrs++;
            $display("error wbValid got %h expected %h at slot %0d",
                     $sampled(wbValid), $sampled(expV), $sampled(retIdx));
        end

    aWbReg: assert property (@(posedge clk) disable iff (!rst)
        wbValid && expV |-> wbReg == expRegNow)
        else begin
            valueErrs++;
            $display("error wbReg got %h expected %h", $sampled(wbReg), $sampled(expRegNow));
        end

    aWbData: assert property (@(posedge clk) disable iff (!rst)
        wbValid && expV |-> wbData == expDataNow)
        else begin
            valueErrs++;
            $display("error wbData got %h expected %h", $sampled(wbData), $sampled(expDataNow));
        end

    // Fetch address starts at the reset PC and steps once per cycle
    aFetchAddr: assert property (@(posedge clk) disable iff (!rst) imemAddr == expAddr)
        else begin
            protoErrs++;
            $display("error imemAddr got %h expected %h",
                     $sampled(imemAddr), $sampled(expAddr));
        end

    initial begin
        int waitCount;
        seed = 32'hb132_bef8;
        clk = 1'b0;
        rst = 1'b0;
        progLen = 0;
        valueErrs = 0;
        presenceErrs = 0;
        protoErrs = 0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < ProgMax; i++) begin
            rom[i] = `RV_NOP;
            expValid[i] = 1'b0;
        end
        // Give every register a known value first
        for (int i = 1; i < 32; i++) begin
            logic [11:0] imm;
            imm = 12'($random(seed));
            modelRegs[i] = {{20{imm[11]}}, imm};
            appendInstr(encI(rvPkg::OpImm, 5'(i), 3'b000, 5'd0, imm), 1'b1, 5'(i),
                        modelRegs[i]);
        end
        for (int i = 0; i < NumRandom; i++) begin
            addRandomInstr();
        end
        imemData = rom[0];

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        waitCount = 0;
        while (imemAddr < (progLen + 8) * 4 && waitCount <= ProgMax + 100) begin
            @(posedge clk);
            waitCount++;
        end

        $display("Errors: value %0d, presence %0d, protocol %0d",
                 valueErrs, presenceErrs, protoErrs);
        if (waitCount > ProgMax + 100) begin
            $display("Timeout waiting for the program to drain");
            $display("sim failed");
        end else if (valueErrs + presenceErrs + protoErrs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
